//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_ooo_core
FILELIST = all.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir

//--- all.f
lc3b_pkg.sv
instr_queue.sv
issue_control.sv
alu_stations.sv
reorder_buffer.sv
reg_rename_file.sv
ooo_core.sv
tb_ooo_core.sv

//--- alu_stations.sv
`timescale 1ns/1ps

module alu_stations #(parameter rob_depth = 8, localparam tag_w = $clog2(rob_depth))
(
	input  logic clk,
	input  logic rst_n,
	output logic [2:0] station_busy,
	input  logic dispatch,
	input  logic [1:0] dispatch_id,
	input  lc3b_pkg::lc3b_opcode dispatch_op,
	input  logic [tag_w-1:0] dispatch_tag,
	input  lc3b_pkg::lc3b_word dispatch_vj,
	input  logic dispatch_jvalid,
	input  logic [tag_w-1:0] dispatch_qj,
	input  lc3b_pkg::lc3b_word dispatch_vk,
	input  logic dispatch_kvalid,
	input  logic [tag_w-1:0] dispatch_qk,
	output logic cdb_valid,
	output logic [tag_w-1:0] cdb_tag,
	output lc3b_pkg::lc3b_word cdb_data
);

lc3b_pkg::lc3b_opcode op [3];
lc3b_pkg::lc3b_word vj [3];
lc3b_pkg::lc3b_word vk [3];
logic [tag_w-1:0] qj [3];
logic [tag_w-1:0] qk [3];
logic [tag_w-1:0] dest [3];
logic [2:0] jvalid;
logic [2:0] kvalid;
logic [2:0] j_hit;
logic [2:0] k_hit;
logic [2:0] ready;
logic [1:0] sel;
lc3b_pkg::lc3b_word result;

assign ready = station_busy & jvalid & kvalid;

// Snoop our own bus for missing operands
always_comb
begin
	for (int i = 0; i < 3; i++)
	begin
		j_hit[i] = cdb_valid && station_busy[i] && !jvalid[i] && (qj[i] == cdb_tag);
		k_hit[i] = cdb_valid && station_busy[i] && !kvalid[i] && (qk[i] == cdb_tag);
	end
end

always_comb
begin
	if (ready[0])
		sel = 2'd0;
	else if (ready[1])
		sel = 2'd1;
	else
		sel = 2'd2;
end

// Shared ALU
always_comb
begin
	case (op[sel])
		lc3b_pkg::op_add: result = vj[sel] + vk[sel];
		lc3b_pkg::op_and: result = vj[sel] & vk[sel];
		default:          result = vj[sel] ^ vk[sel]; // NOT, k is all ones
	endcase
end

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		station_busy <= '0;
		jvalid <= '0;
		kvalid <= '0;
		cdb_valid <= 1'b0;
	end
	else
	begin
		cdb_valid <= |ready;
		jvalid <= jvalid | j_hit;
		kvalid <= kvalid | k_hit;
		if (|ready)
			station_busy[sel] <= 1'b0; // Winner leaves on broadcast
		if (dispatch)
		begin
			station_busy[dispatch_id] <= 1'b1;
			jvalid[dispatch_id] <= dispatch_jvalid;
			kvalid[dispatch_id] <= dispatch_kvalid;
		end
	end
end

always_ff @(posedge clk)
begin
	if (|ready)
	begin
		cdb_tag <= dest[sel];
		cdb_data <= result;
	end
	for (int i = 0; i < 3; i++)
	begin
		if (j_hit[i])
			vj[i] <= cdb_data;
		if (k_hit[i])
			vk[i] <= cdb_data;
	end
	if (dispatch)
	begin
		op[dispatch_id] <= dispatch_op;
		dest[dispatch_id] <= dispatch_tag;
		vj[dispatch_id] <= dispatch_vj;
		qj[dispatch_id] <= dispatch_qj;
		vk[dispatch_id] <= dispatch_vk;
		qk[dispatch_id] <= dispatch_qk;
	end
end

a_dispatch_free: assert property (@(posedge clk) disable iff (!rst_n)
	dispatch |-> !station_busy[dispatch_id])
	else $error("alu_stations: dispatch to busy station %0d", dispatch_id);

endmodule: alu_stations

//--- instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(parameter queue_depth = 4)
(
	input  logic clk,
	input  logic rst_n,
	input  logic instr_valid,
	output logic instr_ready,
	input  lc3b_pkg::lc3b_instr instr,
	output logic head_valid,
	output lc3b_pkg::lc3b_instr head_instr,
	input  logic head_pop
);

localparam ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
localparam cnt_w = $clog2(queue_depth + 1);

lc3b_pkg::lc3b_instr mem [queue_depth];
logic [ptr_w-1:0] wr_ptr;
logic [ptr_w-1:0] rd_ptr;
logic [cnt_w-1:0] count;
logic [cnt_w-1:0] count_next;
logic push;

assign push = instr_valid && instr_ready;
assign head_valid = (count != '0);
assign head_instr = mem[rd_ptr];

always_comb
begin
	count_next = count;
	if (push && !head_pop)
		count_next = count + 1'b1;
	else if (!push && head_pop)
		count_next = count - 1'b1;
end

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		instr_ready <= 1'b0;
	end
	else
	begin
		if (push)
			wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
		if (head_pop)
			rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
		count <= count_next;
		instr_ready <= (count_next != cnt_w'(queue_depth)); // Not full next cycle
	end
end

always_ff @(posedge clk)
begin
	if (push)
		mem[wr_ptr] <= instr;
end

// Issue must never pop an empty queue
a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n) head_pop |-> head_valid)
	else $error("instr_queue: pop while empty");

endmodule: instr_queue

//--- issue_control.sv
`timescale 1ns/1ps

module issue_control #(parameter rob_depth = 8, localparam tag_w = $clog2(rob_depth))
(
	// Instruction queue
	input  logic head_valid,
	input  lc3b_pkg::lc3b_instr head_instr,
	output logic head_pop,
	// Register file
	output lc3b_pkg::lc3b_reg rd_sr1,
	output lc3b_pkg::lc3b_reg rd_sr2,
	input  lc3b_pkg::lc3b_word sr1_value,
	input  logic sr1_busy,
	input  logic [tag_w-1:0] sr1_tag,
	input  lc3b_pkg::lc3b_word sr2_value,
	input  logic sr2_busy,
	input  logic [tag_w-1:0] sr2_tag,
	// Results already in the ROB but not yet committed
	input  logic sr1_rob_done,
	input  lc3b_pkg::lc3b_word sr1_rob_value,
	input  logic sr2_rob_done,
	input  lc3b_pkg::lc3b_word sr2_rob_value,
	// CDB
	input  logic cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  lc3b_pkg::lc3b_word cdb_data,
	// ROB
	input  logic [2:0] station_busy,
	input  logic rob_full,
	input  logic [tag_w-1:0] rob_tail,
	output logic rob_alloc,
	output lc3b_pkg::lc3b_reg rob_dest,
	output logic rename_en,
	output lc3b_pkg::lc3b_reg rename_reg,
	output logic [tag_w-1:0] rename_tag,
	// Reservation stations
	output logic dispatch,
	output logic [1:0] dispatch_id,
	output lc3b_pkg::lc3b_opcode dispatch_op,
	output logic [tag_w-1:0] dispatch_tag,
	output lc3b_pkg::lc3b_word dispatch_vj,
	output logic dispatch_jvalid,
	output logic [tag_w-1:0] dispatch_qj,
	output lc3b_pkg::lc3b_word dispatch_vk,
	output logic dispatch_kvalid,
	output logic [tag_w-1:0] dispatch_qk
);

lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_word imm_sext;
logic is_alu;
logic stall;
logic alloc;

assign opcode = head_instr.r.opcode;
assign imm_sext = {{11{head_instr.i.imm5[4]}}, head_instr.i.imm5};
assign rd_sr1 = head_instr.r.sr1;
assign rd_sr2 = head_instr.r.sr2;

assign is_alu = (opcode == lc3b_pkg::op_add) || (opcode == lc3b_pkg::op_and) ||
	(opcode == lc3b_pkg::op_not);
assign stall = rob_full || (&station_busy);
assign alloc = head_valid && is_alu && !stall;
assign head_pop = head_valid && (alloc || !is_alu); // Other opcodes just fall out

assign rob_alloc = alloc;
assign rob_dest = head_instr.r.dr;
assign rename_en = alloc;
assign rename_reg = head_instr.r.dr;
assign rename_tag = rob_tail; // Tag is the ROB slot
assign dispatch = alloc;
assign dispatch_op = opcode;
assign dispatch_tag = rob_tail;
assign dispatch_qj = sr1_tag;
assign dispatch_qk = sr2_tag;

// Lowest free station
always_comb
begin
	if (!station_busy[0])
		dispatch_id = 2'd0;
	else if (!station_busy[1])
		dispatch_id = 2'd1;
	else
		dispatch_id = 2'd2;
end

always_comb
begin
	dispatch_jvalid = 1'b1;
	if (!sr1_busy)
		dispatch_vj = sr1_value;
	else if (cdb_valid && cdb_tag == sr1_tag)
		dispatch_vj = cdb_data; // Bypass from the bus
	else if (sr1_rob_done)
		dispatch_vj = sr1_rob_value;
	else
	begin
		dispatch_vj = '0;
		dispatch_jvalid = 1'b0; // Wait on sr1_tag
	end
end

always_comb
begin
	dispatch_kvalid = 1'b1;
	if (opcode == lc3b_pkg::op_not)
		dispatch_vk = '1; // XOR with ones gives NOT
	else if (head_instr.i.imm)
		dispatch_vk = imm_sext;
	else if (!sr2_busy)
		dispatch_vk = sr2_value;
	else if (cdb_valid && cdb_tag == sr2_tag)
		dispatch_vk = cdb_data;
	else if (sr2_rob_done)
		dispatch_vk = sr2_rob_value;
	else
	begin
		dispatch_vk = '0;
		dispatch_kvalid = 1'b0;
	end
end

endmodule: issue_control

//--- lc3b_pkg.sv
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Bit 5 picks which view applies
	typedef union packed {
		struct packed {
			lc3b_opcode opcode;
			lc3b_reg    dr;
			lc3b_reg    sr1;
			logic       imm;
			logic [1:0] unused;
			lc3b_reg    sr2;
		} r;
		struct packed {
			lc3b_opcode opcode;
			lc3b_reg    dr;
			lc3b_reg    sr1;
			logic       imm;
			logic [4:0] imm5;
		} i;
	} lc3b_instr;

endpackage: lc3b_pkg

//--- ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(parameter queue_depth = 4, parameter rob_depth = 8,
	localparam tag_w = $clog2(rob_depth))
(
	input  logic clk,
	input  logic rst_n,
	input  logic instr_valid,
	output logic instr_ready,
	input  lc3b_pkg::lc3b_instr instr,
	output logic commit_valid,
	output lc3b_pkg::lc3b_reg commit_reg,
	output lc3b_pkg::lc3b_word commit_value
);

lc3b_pkg::lc3b_instr head_instr;
logic head_valid, head_pop;
lc3b_pkg::lc3b_reg rd_sr1, rd_sr2, rob_dest, rename_reg;
lc3b_pkg::lc3b_word sr1_value, sr2_value, sr1_rob_value, sr2_rob_value;
logic sr1_busy, sr2_busy, sr1_rob_done, sr2_rob_done;
logic [tag_w-1:0] sr1_tag, sr2_tag, rob_tail, rename_tag, commit_tag;
logic rob_full, rob_alloc, rename_en;
logic [2:0] station_busy;
logic dispatch, dispatch_jvalid, dispatch_kvalid;
logic [1:0] dispatch_id;
lc3b_pkg::lc3b_opcode dispatch_op;
logic [tag_w-1:0] dispatch_tag, dispatch_qj, dispatch_qk;
lc3b_pkg::lc3b_word dispatch_vj, dispatch_vk;
logic cdb_valid;
logic [tag_w-1:0] cdb_tag;
lc3b_pkg::lc3b_word cdb_data;

instr_queue #(.queue_depth(queue_depth)) queue0 (
	.clk(clk), .rst_n(rst_n),
	.instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
	.head_valid(head_valid), .head_instr(head_instr), .head_pop(head_pop)
);

issue_control #(.rob_depth(rob_depth)) issue0 (
	.head_valid(head_valid), .head_instr(head_instr), .head_pop(head_pop),
	.rd_sr1(rd_sr1), .rd_sr2(rd_sr2),
	.sr1_value(sr1_value), .sr1_busy(sr1_busy), .sr1_tag(sr1_tag),
	.sr2_value(sr2_value), .sr2_busy(sr2_busy), .sr2_tag(sr2_tag),
	.sr1_rob_done(sr1_rob_done), .sr1_rob_value(sr1_rob_value),
	.sr2_rob_done(sr2_rob_done), .sr2_rob_value(sr2_rob_value),
	.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
	.station_busy(station_busy), .rob_full(rob_full), .rob_tail(rob_tail),
	.rob_alloc(rob_alloc), .rob_dest(rob_dest),
	.rename_en(rename_en), .rename_reg(rename_reg), .rename_tag(rename_tag),
	.dispatch(dispatch), .dispatch_id(dispatch_id), .dispatch_op(dispatch_op),
	.dispatch_tag(dispatch_tag),
	.dispatch_vj(dispatch_vj), .dispatch_jvalid(dispatch_jvalid), .dispatch_qj(dispatch_qj),
	.dispatch_vk(dispatch_vk), .dispatch_kvalid(dispatch_kvalid), .dispatch_qk(dispatch_qk)
);

alu_stations #(.rob_depth(rob_depth)) stations0 (
	.clk(clk), .rst_n(rst_n), .station_busy(station_busy),
	.dispatch(dispatch), .dispatch_id(dispatch_id), .dispatch_op(dispatch_op),
	.dispatch_tag(dispatch_tag),
	.dispatch_vj(dispatch_vj), .dispatch_jvalid(dispatch_jvalid), .dispatch_qj(dispatch_qj),
	.dispatch_vk(dispatch_vk), .dispatch_kvalid(dispatch_kvalid), .dispatch_qk(dispatch_qk),
	.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
);

// ROB lookups follow the tags read from the register file
reorder_buffer #(.rob_depth(rob_depth)) rob0 (
	.clk(clk), .rst_n(rst_n),
	.rob_alloc(rob_alloc), .rob_dest(rob_dest), .rob_full(rob_full), .rob_tail(rob_tail),
	.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
	.rd_tag1(sr1_tag), .rd_tag2(sr2_tag),
	.rd_done1(sr1_rob_done), .rd_value1(sr1_rob_value),
	.rd_done2(sr2_rob_done), .rd_value2(sr2_rob_value),
	.commit_valid(commit_valid), .commit_reg(commit_reg),
	.commit_value(commit_value), .commit_tag(commit_tag)
);

reg_rename_file #(.rob_depth(rob_depth)) regs0 (
	.clk(clk), .rst_n(rst_n),
	.rd_sr1(rd_sr1), .rd_sr2(rd_sr2),
	.sr1_value(sr1_value), .sr1_busy(sr1_busy), .sr1_tag(sr1_tag),
	.sr2_value(sr2_value), .sr2_busy(sr2_busy), .sr2_tag(sr2_tag),
	.rename_en(rename_en), .rename_reg(rename_reg), .rename_tag(rename_tag),
	.commit_valid(commit_valid), .commit_reg(commit_reg),
	.commit_value(commit_value), .commit_tag(commit_tag)
);

endmodule: ooo_core

//--- reg_rename_file.sv
`timescale 1ns/1ps

module reg_rename_file #(parameter rob_depth = 8, localparam tag_w = $clog2(rob_depth))
(
	input  logic clk,
	input  logic rst_n,
	input  lc3b_pkg::lc3b_reg rd_sr1,
	input  lc3b_pkg::lc3b_reg rd_sr2,
	output lc3b_pkg::lc3b_word sr1_value,
	output logic sr1_busy,
	output logic [tag_w-1:0] sr1_tag,
	output lc3b_pkg::lc3b_word sr2_value,
	output logic sr2_busy,
	output logic [tag_w-1:0] sr2_tag,
	input  logic rename_en,
	input  lc3b_pkg::lc3b_reg rename_reg,
	input  logic [tag_w-1:0] rename_tag,
	input  logic commit_valid,
	input  lc3b_pkg::lc3b_reg commit_reg,
	input  lc3b_pkg::lc3b_word commit_value,
	input  logic [tag_w-1:0] commit_tag
);

lc3b_pkg::lc3b_word value [8];
logic [7:0] busy;
logic [tag_w-1:0] tag [8];

assign sr1_value = value[rd_sr1];
assign sr1_busy = busy[rd_sr1];
assign sr1_tag = tag[rd_sr1];
assign sr2_value = value[rd_sr2];
assign sr2_busy = busy[rd_sr2];
assign sr2_tag = tag[rd_sr2];

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		busy <= '0;
		for (int i = 0; i < 8; i++)
			value[i] <= '0;
	end
	else
	begin
		if (commit_valid)
		begin
			value[commit_reg] <= commit_value;
			if (tag[commit_reg] == commit_tag) // Newer rename keeps it busy
				busy[commit_reg] <= 1'b0;
		end
		if (rename_en)
			busy[rename_reg] <= 1'b1; // Wins over a same-cycle commit
	end
end

always_ff @(posedge clk)
begin
	if (rename_en)
		tag[rename_reg] <= rename_tag;
end

endmodule: reg_rename_file

//--- reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(parameter rob_depth = 8, localparam tag_w = $clog2(rob_depth))
(
	input  logic clk,
	input  logic rst_n,
	input  logic rob_alloc,
	input  lc3b_pkg::lc3b_reg rob_dest,
	output logic rob_full,
	output logic [tag_w-1:0] rob_tail,
	input  logic cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  lc3b_pkg::lc3b_word cdb_data,
	// Lookup of finished results for issue
	input  logic [tag_w-1:0] rd_tag1,
	input  logic [tag_w-1:0] rd_tag2,
	output logic rd_done1,
	output lc3b_pkg::lc3b_word rd_value1,
	output logic rd_done2,
	output lc3b_pkg::lc3b_word rd_value2,
	output logic commit_valid,
	output lc3b_pkg::lc3b_reg commit_reg,
	output lc3b_pkg::lc3b_word commit_value,
	output logic [tag_w-1:0] commit_tag
);

lc3b_pkg::lc3b_reg dest [rob_depth];
lc3b_pkg::lc3b_word value [rob_depth];
logic [rob_depth-1:0] done;
logic [tag_w-1:0] head;
logic [tag_w-1:0] tail;
logic [tag_w-1:0] cdb_offset;
logic [tag_w:0] count;
logic retire;

assign rob_full = (count == (tag_w+1)'(rob_depth));
assign rob_tail = tail;
assign retire = (count != '0) && done[head];
assign cdb_offset = cdb_tag - head; // Distance from head, wraps with depth

// Done stays set after retire until the slot is reused
assign rd_done1 = done[rd_tag1];
assign rd_value1 = value[rd_tag1];
assign rd_done2 = done[rd_tag2];
assign rd_value2 = value[rd_tag2];

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		done <= '0;
		commit_valid <= 1'b0;
	end
	else
	begin
		if (rob_alloc)
		begin
			done[tail] <= 1'b0;
			tail <= tail + 1'b1;
		end
		if (cdb_valid)
			done[cdb_tag] <= 1'b1;
		if (retire)
			head <= head + 1'b1;
		commit_valid <= retire;
		count <= count + {{tag_w{1'b0}}, rob_alloc} - {{tag_w{1'b0}}, retire};
	end
end

always_ff @(posedge clk)
begin
	if (rob_alloc)
		dest[tail] <= rob_dest;
	if (cdb_valid)
		value[cdb_tag] <= cdb_data;
	if (retire)
	begin
		commit_reg <= dest[head];
		commit_value <= value[head];
		commit_tag <= head;
	end
end

a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n) rob_alloc |-> !rob_full)
	else $error("reorder_buffer: allocation while full");

// A broadcast must land on a live entry still waiting for its result
a_cdb_live: assert property (@(posedge clk) disable iff (!rst_n)
	cdb_valid |-> ({1'b0, cdb_offset} < count) && !done[cdb_tag])
	else $error("reorder_buffer: CDB tag %0d not pending", cdb_tag);

endmodule: reorder_buffer

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

localparam int phase1_len = 16;
localparam int phase2_len = 16;
localparam int phase3_len = 16;
localparam int phase4_len = 20;
localparam int phase5_len = 64;
localparam int num_words = phase1_len + phase2_len + phase3_len + phase4_len + phase5_len;
localparam int cycle_limit = 20 * num_words + 200;

logic clk;
logic rst_n;
logic instr_valid;
logic instr_ready;
lc3b_pkg::lc3b_instr instr;
logic commit_valid;
lc3b_pkg::lc3b_reg commit_reg;
lc3b_pkg::lc3b_word commit_value;

lc3b_pkg::lc3b_word model_regs [8]; // In-order architectural state
lc3b_pkg::lc3b_reg exp_reg_q [$];
lc3b_pkg::lc3b_word exp_val_q [$];
int alu_sent;
int commits;
int cycles;
int queue_stalls; // Negedges with valid high and ready low

ooo_core #(.queue_depth(4), .rob_depth(8)) dut0 (
	.clk(clk), .rst_n(rst_n),
	.instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr),
	.commit_valid(commit_valid), .commit_reg(commit_reg), .commit_value(commit_value)
);

initial
begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Test FAILED");
	$fatal(1, "simulation stopped");
endtask

task automatic check_value(input string what, input int unsigned got, input int unsigned expected);
	if (got != expected)
		abort_run($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, what, got, expected));
endtask

// Executes one word in order and returns 0 for opcodes that write nothing
function automatic bit ref_exec(input lc3b_pkg::lc3b_instr w, output lc3b_pkg::lc3b_reg dr,
	output lc3b_pkg::lc3b_word value);
	lc3b_pkg::lc3b_word a;
	lc3b_pkg::lc3b_word b;
	a = model_regs[w.r.sr1];
	if (w.i.imm)
		b = {{11{w.i.imm5[4]}}, w.i.imm5};
	else
		b = model_regs[w.r.sr2];
	dr = w.r.dr;
	case (w.r.opcode)
		lc3b_pkg::op_add: value = a + b;
		lc3b_pkg::op_and: value = a & b;
		lc3b_pkg::op_not: value = ~a;
		default:
		begin
			value = '0;
			return 1'b0;
		end
	endcase
	model_regs[dr] = value;
	return 1'b1;
endfunction

function automatic lc3b_pkg::lc3b_instr make_instr(input lc3b_pkg::lc3b_opcode op,
	input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1, input logic imm,
	input logic [4:0] low5);
	lc3b_pkg::lc3b_instr w;
	w.i.opcode = op;
	w.i.dr = dr;
	w.i.sr1 = sr1;
	w.i.imm = imm;
	w.i.imm5 = imm ? low5 : {2'b00, low5[2:0]}; // Unused bits stay zero
	return w;
endfunction

function automatic lc3b_pkg::lc3b_opcode pick_alu_op();
	case ($urandom_range(2, 0))
		0: return lc3b_pkg::op_add;
		1: return lc3b_pkg::op_and;
		default: return lc3b_pkg::op_not;
	endcase
endfunction

function automatic lc3b_pkg::lc3b_instr random_alu(input lc3b_pkg::lc3b_opcode op,
	input lc3b_pkg::lc3b_reg dr);
	return make_instr(op, dr, lc3b_pkg::lc3b_reg'($urandom_range(7, 0)), 1'($urandom),
		5'($urandom));
endfunction

// Called and returns just after a falling edge
task automatic send(input lc3b_pkg::lc3b_instr w, input bit gaps);
	int idle;
	lc3b_pkg::lc3b_reg dr;
	lc3b_pkg::lc3b_word value;
	idle = gaps ? int'($urandom_range(2, 0)) : 0;
	repeat (idle)
	begin
		instr_valid = 1'b0;
		@(negedge clk);
	end
	instr_valid = 1'b1;
	instr = w;
	while (!instr_ready)
	begin
		queue_stalls++;
		@(negedge clk); // Ready is registered, stable until the next rising edge
	end
	if (ref_exec(w, dr, value))
	begin
		exp_reg_q.push_back(dr);
		exp_val_q.push_back(value);
		alu_sent++;
	end
	@(negedge clk);
endtask

// Commit outputs are registered, so look at them mid-cycle
always @(negedge clk)
begin : commit_check
	lc3b_pkg::lc3b_reg e_reg;
	lc3b_pkg::lc3b_word e_val;
	if (rst_n && commit_valid)
	begin
		if (exp_reg_q.size() == 0)
			abort_run($sformatf("Commit at %0t with no instruction outstanding", $time));
		e_reg = exp_reg_q.pop_front();
		e_val = exp_val_q.pop_front();
		check_value("commit_reg", int'(commit_reg), int'(e_reg));
		check_value("commit_value", int'(commit_value), int'(e_val));
		commits++;
	end
end

always @(posedge clk)
begin
	cycles++;
	if (cycles >= cycle_limit)
		abort_run($sformatf("Timeout after %0d cycles, %0d of %0d commits seen",
			cycles, commits, alu_sent));
end

initial
begin
	lc3b_pkg::lc3b_opcode op;
	void'($urandom(75));
	rst_n = 1'b0;
	instr_valid = 1'b0;
	instr = '0;
	alu_sent = 0;
	commits = 0;
	cycles = 0;
	queue_stalls = 0;
	for (int i = 0; i < 8; i++)
		model_regs[i] = '0;
	repeat (5) @(posedge clk);
	@(negedge clk);
	check_value("instr_ready in reset", int'(instr_ready), 0);
	check_value("commit_valid in reset", int'(commit_valid), 0);
	rst_n = 1'b1;

	// Seed every register, then a mix with distinct destinations
	for (int i = 0; i < 8; i++)
		send(make_instr(lc3b_pkg::op_add, 3'(i), 3'(i), 1'b1, 5'($urandom)), 1'b1);
	for (int i = 0; i < phase1_len - 8; i++)
		send(random_alu($urandom_range(1, 0) ? lc3b_pkg::op_add : lc3b_pkg::op_and, 3'(i)),
			1'b1);

	// Two interleaved chains sent back to back
	for (int i = 0; i < phase2_len; i++)
		send(make_instr(pick_alu_op(), 3'(i % 2), 3'(i % 2), 1'($urandom),
			5'($urandom)), 1'b0);

	// Many renames of r3 with readers in between
	for (int i = 0; i < phase3_len; i++)
	begin
		if (i % 4 == 3)
			send(make_instr(lc3b_pkg::op_add, 3'd4, 3'd3, 1'b0, 5'd3), 1'b1);
		else
			send(make_instr(pick_alu_op(), 3'd3, 3'd3, 1'($urandom), 5'($urandom)), 1'b1);
	end

	for (int i = 0; i < phase4_len; i++)
	begin
		if (i % 2 == 1)
		begin
			do
				op = lc3b_pkg::lc3b_opcode'(4'($urandom));
			while (op == lc3b_pkg::op_add || op == lc3b_pkg::op_and || op == lc3b_pkg::op_not);
			send(lc3b_pkg::lc3b_instr'({op, 12'($urandom)}), 1'b1);
		end
		else
			send(random_alu(pick_alu_op(), lc3b_pkg::lc3b_reg'($urandom_range(7, 0))), 1'b1);
	end

	// Burst with valid held high to fill stations and ROB
	queue_stalls = 0;
	for (int i = 0; i < phase5_len; i++)
		send(random_alu(pick_alu_op(), lc3b_pkg::lc3b_reg'($urandom_range(7, 0))), 1'b0);
	instr_valid = 1'b0;

	while (commits < alu_sent)
		@(negedge clk);
	repeat (20) @(negedge clk); // Catch stray commits
	if (queue_stalls == 0)
		abort_run("The burst never stalled the queue, instr_ready stayed high throughout");
	else
	begin
		$display("Test OK");
		$finish;
	end
end

endmodule: tb_ooo_core
